//--- fetchFront_defines.svh
`ifndef FETCH_FRONT_DEFINES_SVH
`define FETCH_FRONT_DEFINES_SVH

// boot vector, start of the uncached boot rom
`define RESET_PC 32'hbfc00000

// log2 of predictor lines, 16 lines of two slots each
`define NLP_INDEX_BITS 4

// request queue entries toward the icache
`define FETCH_QUEUE_DEPTH 4

// one-bit constants
`define TRUE 1'b1
`define FALSE 1'b0

`endif

//--- fetchPkg.sv
`default_nettype none

package fetchPkg;

    // prediction for one instruction slot
    typedef struct packed {
        logic        valid;
        // taken bit, the only direction info kept
        logic        taken;
        logic [31:0] target;
    } nlpInfo_t;

    // training write from the backend
    typedef struct packed {
        // one-cycle strobe
        logic        valid;
        // pc of the branch itself, bit 2 picks the slot
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
    } nlpUpdate_t;

    // redirect from backend or a later fetch stage
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } redirect_t;

    // one instruction slot of a fetch line
    typedef struct packed {
        // word aligned
        logic [31:0] pc;
        nlpInfo_t    nlpInfo;
    } fetchSlot_t;

    // one request to the icache, a full 8-byte line
    typedef struct packed {
        logic       valid;
        // line fetched only for the delay slot in slot0
        logic       onlyGetDS;
        fetchSlot_t slot0;
        fetchSlot_t slot1;
    } fetchPacket_t;

endpackage

`default_nettype wire

//--- nextLinePredictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetchFront_defines.svh"

module nextLinePredictor (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  wire logic [31:0]          pc,
    input  fetchPkg::nlpUpdate_t      train,
    output fetchPkg::nlpInfo_t        lookup0,
    output fetchPkg::nlpInfo_t        lookup1
);

    localparam int IdxBits  = `NLP_INDEX_BITS;
    localparam int NumLines = 1 << IdxBits;
    // bits 2..0 select byte and slot within the line
    localparam int TagBits  = 32 - 3 - IdxBits;

    // one stored entry, its valid bit lives in entryValid
    typedef struct packed {
        logic [TagBits-1:0] tag;
        logic               taken;
        logic [31:0]        target;
    } nlpEntry_t;

    // lookup side, from the current fetch pc
    logic [IdxBits-1:0] rdIdx;
    logic [TagBits-1:0] rdTag;

    // training side, from the branch pc
    logic [IdxBits-1:0] wrIdx;
    logic [TagBits-1:0] wrTag;

    // per-slot results before splitting into the two outputs
    fetchPkg::nlpInfo_t lookupArr [2];

    assign rdIdx = pc[3 +: IdxBits];
    assign rdTag = pc[31 -: TagBits];

    assign wrIdx = train.pc[3 +: IdxBits];
    assign wrTag = train.pc[31 -: TagBits];

    // identical table per slot
    for (genvar s = 0; s < 2; s++) begin : gSlot
        logic [NumLines-1:0] entryValid;
        nlpEntry_t           entryTable [NumLines];
        nlpEntry_t           rdEntry;
        logic                wrEn;
        logic                tagHit;

        // slot chosen by bit 2 of the branch pc
        assign wrEn = train.valid && (train.pc[2] == 1'(s));

        // valid bits, cleared on reset
        always_ff @(posedge clk) begin
            if (rst) begin
                entryValid <= '0;
            end else if (wrEn) begin
                entryValid[wrIdx] <= `TRUE;
            end
        end

        // tag, taken and target storage
        always_ff @(posedge clk) begin
            if (wrEn) begin
                entryTable[wrIdx].tag    <= wrTag;
                entryTable[wrIdx].taken  <= train.taken;
                entryTable[wrIdx].target <= train.target;
            end
        end

        // same-cycle read
        assign rdEntry = entryTable[rdIdx];
        assign tagHit  = (rdEntry.tag == rdTag);

        // valid only when the tag matches
        assign lookupArr[s].valid  = entryValid[rdIdx] && tagHit;
        assign lookupArr[s].taken  = rdEntry.taken;
        assign lookupArr[s].target = rdEntry.target;
    end

    assign lookup0 = lookupArr[0];
    assign lookup1 = lookupArr[1];

endmodule

`default_nettype wire

//--- fetchPcGen.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetchFront_defines.svh"

module fetchPcGen (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  fetchPkg::redirect_t       backendRedirect,
    input  fetchPkg::redirect_t       laterRedirect,
    input  fetchPkg::nlpInfo_t        lookup0,
    input  fetchPkg::nlpInfo_t        lookup1,
    input  wire logic                 almostFull,
    output logic [31:0]               pc,
    output fetchPkg::fetchPacket_t    packet,
    output logic                      flush
);

    logic [31:0] pcReg;
    // set while the line after a taken slot1 branch is out for its delay slot
    logic        dsFlag;
    // predicted target waiting behind the delay slot
    logic [31:0] dsTarget;

    logic [31:0] nextLine;
    logic        slot0Taken;
    logic        slot1Taken;
    logic        saveTarget;

    // sequential line, always 8-byte aligned
    assign nextLine = {pcReg[31:3], 3'b000} + 32'd8;

    // slot0 prediction ignored when entering the line at slot1
    assign slot0Taken = lookup0.valid && lookup0.taken && !pcReg[2];
    assign slot1Taken = lookup1.valid && lookup1.taken;

    // any redirect wipes the queue
    assign flush = backendRedirect.valid || laterRedirect.valid;

    // same conditions that reach the slot1 branch below
    assign saveTarget = !flush && !almostFull && !dsFlag && !slot0Taken && slot1Taken;

    // pc and delay-slot flag, priority chain
    always_ff @(posedge clk) begin
        if (rst) begin
            pcReg  <= `RESET_PC;
            dsFlag <= `FALSE;
        end else if (backendRedirect.valid) begin
            // backend wins over the later stage
            pcReg  <= backendRedirect.pc;
            dsFlag <= `FALSE;
        end else if (laterRedirect.valid) begin
            pcReg  <= laterRedirect.pc;
            dsFlag <= `FALSE;
        end else if (almostFull) begin
            // queue nearly full, hold everything
            pcReg  <= pcReg;
            dsFlag <= dsFlag;
        end else if (dsFlag) begin
            // delay slot line was sent, now go to the target
            pcReg  <= dsTarget;
            dsFlag <= `FALSE;
        end else if (slot0Taken) begin
            pcReg  <= lookup0.target;
            dsFlag <= `FALSE;
        end else if (slot1Taken) begin
            // fetch the delay slot first
            pcReg  <= nextLine;
            dsFlag <= `TRUE;
        end else begin
            pcReg  <= nextLine;
            dsFlag <= `FALSE;
        end
    end

    // saved target, only meaningful while dsFlag is set
    always_ff @(posedge clk) begin
        if (saveTarget) begin
            dsTarget <= lookup1.target;
        end
    end

    assign pc = pcReg;

    // fetch packet from the current line
    always_comb begin
        packet.valid             = !flush && !almostFull;
        packet.onlyGetDS         = dsFlag;
        packet.slot0.pc          = {pcReg[31:3], 3'b000};
        packet.slot0.nlpInfo     = lookup0;
        packet.slot1.pc          = {pcReg[31:3], 3'b100};
        packet.slot1.nlpInfo     = lookup1;
    end

endmodule

`default_nettype wire

//--- fetchReqQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetchFront_defines.svh"

module fetchReqQueue (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  fetchPkg::fetchPacket_t    packet,
    input  wire logic                 flush,
    input  wire logic                 reqAccept,
    output fetchPkg::fetchPacket_t    fetchReq,
    output logic                      almostFull
);

    localparam int Depth   = `FETCH_QUEUE_DEPTH;
    localparam int PtrBits = $clog2(Depth);
    // count must also hold the value Depth
    localparam int CntBits = $clog2(Depth + 1);

    fetchPkg::fetchPacket_t entries [Depth];

    logic [PtrBits-1:0] wrPtr;
    logic [PtrBits-1:0] rdPtr;
    logic [CntBits-1:0] count;

    logic doPush;
    logic doPop;

    assign doPush = packet.valid;
    // cache strobe ignored on an empty queue
    assign doPop  = reqAccept && (count != '0);

    // pointers and count, flush beats push and pop
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) begin
                wrPtr <= (wrPtr == PtrBits'(Depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (doPop) begin
                rdPtr <= (rdPtr == PtrBits'(Depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            // push and pop together leave count unchanged
            if (doPush && !doPop) begin
                count <= count + 1'b1;
            end else if (doPop && !doPush) begin
                count <= count - 1'b1;
            end
        end
    end

    // packet storage
    always_ff @(posedge clk) begin
        if (doPush) begin
            entries[wrPtr] <= packet;
        end
    end

    // head entry, valid means not empty
    always_comb begin
        fetchReq       = entries[rdPtr];
        fetchReq.valid = (count != '0);
    end

    // one slot of slack for the packet already in flight
    assign almostFull = (count >= CntBits'(Depth - 1));

endmodule

`default_nettype wire

//--- fetchFrontEnd.sv
`timescale 1ns/1ps
`default_nettype none

module fetchFrontEnd (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  fetchPkg::redirect_t       backendRedirect,
    input  fetchPkg::redirect_t       laterRedirect,
    input  fetchPkg::nlpUpdate_t      nlpTrain,
    input  wire logic                 reqAccept,
    output fetchPkg::fetchPacket_t    fetchReq
);

    // current fetch pc into the predictor
    logic [31:0] pc;

    // same-cycle predictions for both slots
    fetchPkg::nlpInfo_t lookup0;
    fetchPkg::nlpInfo_t lookup1;

    // pc generator to queue
    fetchPkg::fetchPacket_t packet;
    logic                   flush;
    // back-pressure from the queue
    logic                   almostFull;

    nextLinePredictor nlp0 (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .train   (nlpTrain),
        .lookup0 (lookup0),
        .lookup1 (lookup1)
    );

    fetchPcGen pcGen0 (
        .clk             (clk),
        .rst             (rst),
        .backendRedirect (backendRedirect),
        .laterRedirect   (laterRedirect),
        .lookup0         (lookup0),
        .lookup1         (lookup1),
        .almostFull      (almostFull),
        .pc              (pc),
        .packet          (packet),
        .flush           (flush)
    );

    // requests wait here for the icache
    fetchReqQueue reqQueue0 (
        .clk        (clk),
        .rst        (rst),
        .packet     (packet),
        .flush      (flush),
        .reqAccept  (reqAccept),
        .fetchReq   (fetchReq),
        .almostFull (almostFull)
    );

endmodule

`default_nettype wire

//--- fetchFrontEndTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "fetchFront_defines.svh"

module fetchFrontEndTb;

    localparam int WaitLimit = 200;

    logic clk = 1'b0;
    logic rst = 1'b1;
    fetchPkg::redirect_t    backendRedirect = '0;
    fetchPkg::redirect_t    laterRedirect = '0;
    fetchPkg::nlpUpdate_t   nlpTrain = '0;
    logic                   reqAccept = 1'b0;
    fetchPkg::fetchPacket_t fetchReq;

    // keeps reqAccept low while set
    logic acceptHold = 1'b0;

    int errCount = 0;
    int testNum = 0;
    int passCount = 0;
    int failCount = 0;

    // reference model state
    logic [31:0] mPc;
    logic        mFlag;
    logic [31:0] mTarget;
    // packets the queue should hold, oldest first
    fetchPkg::fetchPacket_t expQ [$];
    // packets the cache took since reset or the last redirect
    fetchPkg::fetchPacket_t gotQ [$];
    // trained slots by word pc, {taken, target}
    logic [32:0] predMap [logic [31:0]];

    fetchFrontEnd dut0 (
        .clk             (clk),
        .rst             (rst),
        .backendRedirect (backendRedirect),
        .laterRedirect   (laterRedirect),
        .nlpTrain        (nlpTrain),
        .reqAccept       (reqAccept),
        .fetchReq        (fetchReq)
    );

    always #20 clk = ~clk;

    task automatic reportError(input string msg);
        errCount++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    // model lookup of one slot in a line
    function automatic fetchPkg::nlpInfo_t predictSlot(input logic [31:0] lineBase,
                                                       input logic slot);
        fetchPkg::nlpInfo_t info;
        logic [31:0]        key;
        key = {lineBase[31:3], slot, 2'b00};
        info = '0;
        if (predMap.exists(key)) begin
            info.valid  = 1'b1;
            info.taken  = predMap[key][32];
            info.target = predMap[key][31:0];
        end
        return info;
    endfunction

    // taken and target only count for a valid prediction
    function automatic logic infoMatches(input fetchPkg::nlpInfo_t got,
                                         input fetchPkg::nlpInfo_t want);
        if (got.valid != want.valid) begin
            return 1'b0;
        end
        return !want.valid || (got.taken == want.taken && got.target == want.target);
    endfunction

    task automatic checkPacket(input fetchPkg::fetchPacket_t got,
                               input fetchPkg::fetchPacket_t want);
        assert (got.slot0.pc == want.slot0.pc && got.slot1.pc == want.slot1.pc)
            else reportError($sformatf("slot pcs %h/%h, expected %h/%h",
                got.slot0.pc, got.slot1.pc, want.slot0.pc, want.slot1.pc));
        assert (got.onlyGetDS == want.onlyGetDS)
            else reportError($sformatf("onlyGetDS %b at line %h, expected %b",
                got.onlyGetDS, got.slot0.pc, want.onlyGetDS));
        assert (infoMatches(got.slot0.nlpInfo, want.slot0.nlpInfo))
            else reportError($sformatf("slot0 prediction wrong at line %h", got.slot0.pc));
        assert (infoMatches(got.slot1.nlpInfo, want.slot1.nlpInfo))
            else reportError($sformatf("slot1 prediction wrong at line %h", got.slot0.pc));
    endtask

    // queue comes out of reset empty
    assert property (@(posedge clk) rst |=> !fetchReq.valid)
        else reportError("fetchReq valid in the cycle after a reset edge");

    // random accept pattern from the cache, seeded once for the run
    initial begin : acceptGen
        int seedDummy;
        seedDummy = $urandom(32'hb2d109e3);
        forever begin
            @(posedge clk);
            if (rst || acceptHold) begin
                reqAccept <= 1'b0;
            end else begin
                reqAccept <= ($urandom % 3) != 0;
            end
        end
    end

    // reference model, steps with the DUT on every edge
    always @(posedge clk) begin : refModel
        fetchPkg::fetchPacket_t expPkt;
        fetchPkg::fetchPacket_t headPkt;
        fetchPkg::nlpInfo_t     pred0;
        fetchPkg::nlpInfo_t     pred1;
        logic [31:0]            lineBase;
        logic                   nearFull;
        logic                   redirect;
        if (rst) begin
            mPc   = `RESET_PC;
            mFlag = 1'b0;
            expQ.delete();
            gotQ.delete();
            predMap.delete();
        end else begin
            // stall decided by occupancy before this edge
            nearFull = (expQ.size() >= `FETCH_QUEUE_DEPTH - 1);
            assert (fetchReq.valid == (expQ.size() != 0))
                else reportError($sformatf("fetchReq valid %b with %0d packets expected",
                    fetchReq.valid, expQ.size()));
            if (reqAccept && expQ.size() != 0) begin
                headPkt = expQ.pop_front();
                checkPacket(fetchReq, headPkt);
                gotQ.push_back(fetchReq);
            end
            lineBase = {mPc[31:3], 3'b000};
            pred0 = predictSlot(lineBase, 1'b0);
            pred1 = predictSlot(lineBase, 1'b1);
            redirect = backendRedirect.valid || laterRedirect.valid;
            if (!redirect && !nearFull) begin
                expPkt.valid         = 1'b1;
                expPkt.onlyGetDS     = mFlag;
                expPkt.slot0.pc      = lineBase;
                expPkt.slot0.nlpInfo = pred0;
                expPkt.slot1.pc      = lineBase + 32'd4;
                expPkt.slot1.nlpInfo = pred1;
                expQ.push_back(expPkt);
            end
            if (redirect) begin
                // old path is gone
                expQ.delete();
                gotQ.delete();
            end
            // next pc, backend first
            if (backendRedirect.valid) begin
                mPc   = backendRedirect.pc;
                mFlag = 1'b0;
            end else if (laterRedirect.valid) begin
                mPc   = laterRedirect.pc;
                mFlag = 1'b0;
            end else if (nearFull) begin
                mPc = mPc;
            end else if (mFlag) begin
                mPc   = mTarget;
                mFlag = 1'b0;
            end else if (pred0.valid && pred0.taken && !mPc[2]) begin
                mPc = pred0.target;
            end else if (pred1.valid && pred1.taken) begin
                // delay slot line goes out first
                mTarget = pred1.target;
                mPc     = lineBase + 32'd8;
                mFlag   = 1'b1;
            end else begin
                mPc = lineBase + 32'd8;
            end
            // training seen by lookups from the next cycle
            if (nlpTrain.valid) begin
                predMap[{nlpTrain.pc[31:2], 2'b00}] = {nlpTrain.taken, nlpTrain.target};
            end
        end
    end

    task automatic waitForAccepts(input int n, input string what);
        int cycles;
        cycles = 0;
        while (gotQ.size() < n && cycles < WaitLimit) begin
            @(negedge clk);
            cycles++;
        end
        if (gotQ.size() < n) begin
            errCount++;
            $display("timeout: the wait for %s expired after %0d cycles", what, cycles);
        end
    endtask

    // one-cycle redirect pulse on either or both sources
    task automatic redirectTo(input logic toBackend, input logic [31:0] backendPc,
                              input logic toLater, input logic [31:0] laterPc);
        @(posedge clk);
        backendRedirect.valid <= toBackend;
        backendRedirect.pc    <= backendPc;
        laterRedirect.valid   <= toLater;
        laterRedirect.pc      <= laterPc;
        @(posedge clk);
        backendRedirect.valid <= 1'b0;
        laterRedirect.valid   <= 1'b0;
        @(negedge clk);
    endtask

    task automatic trainLine(input logic [31:0] branchPc, input logic taken,
                             input logic [31:0] target);
        @(posedge clk);
        nlpTrain.valid  <= 1'b1;
        nlpTrain.pc     <= branchPc;
        nlpTrain.taken  <= taken;
        nlpTrain.target <= target;
        @(posedge clk);
        nlpTrain.valid <= 1'b0;
        @(negedge clk);
    endtask

    // accepted lines i..j-1 each follow the one before by 8
    task automatic checkSequential(input int first, input int last, input string what);
        for (int i = first + 1; i < last; i++) begin
            assert (gotQ[i].slot0.pc == gotQ[i-1].slot0.pc + 32'd8)
                else reportError($sformatf("%s: line %h after %h", what,
                    gotQ[i].slot0.pc, gotQ[i-1].slot0.pc));
        end
    endtask

    task automatic endTest(input string name, input int startErr);
        testNum++;
        if (errCount == startErr) begin
            passCount++;
            $display("test %0d %s: passed", testNum, name);
        end else begin
            failCount++;
            $display("test %0d %s: failed", testNum, name);
        end
    endtask

    initial begin : mainSeq
        int startErr;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        // boot vector comes first
        startErr = errCount;
        @(negedge clk);
        assert (!fetchReq.valid) else reportError("fetchReq valid right after reset");
        waitForAccepts(1, "the first packet after reset");
        assert (gotQ[0].slot0.pc == `RESET_PC && gotQ[0].slot1.pc == `RESET_PC + 32'd4
                && !gotQ[0].onlyGetDS)
            else reportError($sformatf("first packet at %h", gotQ[0].slot0.pc));
        endTest("reset and boot vector", startErr);

        // plain sequential fetch under random accepts
        startErr = errCount;
        waitForAccepts(16, "16 sequential packets");
        checkSequential(0, 16, "sequential fetch");
        endTest("sequential lines", startErr);

        // redirects, backend has priority
        startErr = errCount;
        redirectTo(1'b1, 32'h80001000, 1'b0, 32'h0);
        waitForAccepts(3, "packets after a backend redirect");
        assert (gotQ[0].slot0.pc == 32'h80001000)
            else reportError($sformatf("backend redirect went to %h", gotQ[0].slot0.pc));
        checkSequential(0, 3, "after backend redirect");
        redirectTo(1'b0, 32'h0, 1'b1, 32'h80001104);
        waitForAccepts(3, "packets after a later-stage redirect");
        assert (gotQ[0].slot0.pc == 32'h80001100 && gotQ[1].slot0.pc == 32'h80001108)
            else reportError($sformatf("later redirect went to %h", gotQ[0].slot0.pc));
        redirectTo(1'b1, 32'h80001200, 1'b1, 32'h80001300);
        waitForAccepts(2, "packets after two redirects at once");
        assert (gotQ[0].slot0.pc == 32'h80001200)
            else reportError($sformatf("dual redirect went to %h", gotQ[0].slot0.pc));
        endTest("redirects", startErr);

        // slot0 taken, A = 80002000 to T = 80003010
        startErr = errCount;
        trainLine(32'h80002000, 1'b1, 32'h80003010);
        redirectTo(1'b1, 32'h80001ff0, 1'b0, 32'h0);
        waitForAccepts(5, "packets through a slot0 branch");
        assert (gotQ[2].slot0.pc == 32'h80002000 && gotQ[2].slot0.nlpInfo.valid
                && gotQ[2].slot0.nlpInfo.taken)
            else reportError("line A does not carry its slot0 prediction");
        assert (gotQ[3].slot0.pc == 32'h80003010 && gotQ[4].slot0.pc == 32'h80003018)
            else reportError($sformatf("slot0 branch went to %h", gotQ[3].slot0.pc));
        // entering A at its second word skips slot0
        redirectTo(1'b0, 32'h0, 1'b1, 32'h80002004);
        waitForAccepts(2, "packets after entering line A at bit 2");
        assert (gotQ[0].slot0.pc == 32'h80002000 && gotQ[1].slot0.pc == 32'h80002008)
            else reportError($sformatf("entry at bit 2 went on to %h", gotQ[1].slot0.pc));
        endTest("slot0 prediction", startErr);

        // slot1 taken, B = 80004008 to T = 80005020
        startErr = errCount;
        trainLine(32'h8000400c, 1'b1, 32'h80005020);
        redirectTo(1'b1, 32'h80004008, 1'b0, 32'h0);
        waitForAccepts(4, "packets through a slot1 branch");
        assert (gotQ[0].slot1.nlpInfo.valid && gotQ[0].slot1.nlpInfo.taken)
            else reportError("line B does not carry its slot1 prediction");
        assert (gotQ[1].slot0.pc == 32'h80004010 && gotQ[1].onlyGetDS)
            else reportError("delay slot line missing after line B");
        assert (gotQ[2].slot0.pc == 32'h80005020 && !gotQ[2].onlyGetDS)
            else reportError($sformatf("slot1 branch went to %h", gotQ[2].slot0.pc));
        // not taken brings back sequential fetch
        trainLine(32'h8000400c, 1'b0, 32'h80005020);
        redirectTo(1'b1, 32'h80004008, 1'b0, 32'h0);
        waitForAccepts(3, "packets through a not-taken slot1");
        assert (!gotQ[1].onlyGetDS) else reportError("delay slot flag on a not-taken line");
        checkSequential(0, 3, "after not-taken training");
        endTest("slot1 prediction and delay slot", startErr);

        // cache stops accepting, queue must stall the pc
        startErr = errCount;
        @(posedge clk);
        acceptHold <= 1'b1;
        redirectTo(1'b1, 32'h80006000, 1'b0, 32'h0);
        repeat (12) @(negedge clk);
        // pc parked on the line after the last one the queue took
        assert (fetchReq.valid
                && dut0.pc == 32'h80006000 + 32'd8 * (`FETCH_QUEUE_DEPTH - 1))
            else reportError($sformatf("pc %h while the cache is stalled", dut0.pc));
        @(posedge clk);
        acceptHold <= 1'b0;
        waitForAccepts(8, "packets after the cache resumed");
        assert (gotQ[0].slot0.pc == 32'h80006000)
            else reportError($sformatf("resumed at %h", gotQ[0].slot0.pc));
        checkSequential(0, 8, "after back-pressure");
        endTest("back-pressure", startErr);

        $display("summary: %0d passed, %0d failed, %0d errors", passCount, failCount,
                 errCount);
        if (errCount == 0 && failCount == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- fetchFrontEnd.f
+incdir+.
fetchPkg.sv
nextLinePredictor.sv
fetchPcGen.sv
fetchReqQueue.sv
fetchFrontEnd.sv
fetchFrontEndTb.sv

//--- runSim.sh
#!/bin/sh
# build and run the fetch front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module fetchFrontEndTb -f fetchFrontEnd.f -o fetchSim \
    || { echo "verilator build error"; exit 1; }

simOut=$(./obj_dir/fetchSim)
echo "$simOut"

# result taken from the printed summary
echo "$simOut" | grep -qx "all tests passed" && exit 0 || exit 1
